// File: include/id_macros.svh
// ----------------------------------------
// Decode stage parameters
// Lane count and datapath widths shared by
// the package, the RTL and the testbench
// ----------------------------------------

`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Decode lanes and issue slots
`define ID_NR_LANES 2

// PC and immediate width
`define ID_XLEN 32

// Register address width
`define ID_REG_ADDR_W 5

`endif

// File: design/id_pkg.sv
// ----------------------------------------
// Decode stage package
// Vector types, operation classes and the
// base opcodes seen by the decode lanes
// ----------------------------------------

`include "id_macros.svh"

package id_pkg;

  // Datapath vectors
  typedef logic [31:0]                 instr_t;
  typedef logic [15:0]                 cinstr_t;
  typedef logic [`ID_XLEN-1:0]         pc_t;
  typedef logic [`ID_REG_ADDR_W-1:0]   reg_addr_t;
  typedef logic [`ID_XLEN-1:0]         imm_t;

  // Coarse class handed to issue
  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_ALU    = 3'd1,
    OP_LOAD   = 3'd2,
    OP_STORE  = 3'd3,
    OP_BRANCH = 3'd4,
    OP_JUMP   = 3'd5
  } op_class_e;

  // ----------------------------------------
  // RV32 base opcodes
  // ----------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

// File: design/id_lane_if.sv
// ----------------------------------------
// Decoded entry of one lane
// Carries the decoder result to the issue
// register; validity comes from fetch
// ----------------------------------------

interface id_lane_if;
  import id_pkg::*;

  op_class_e op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  imm_t      imm;
  pc_t       pc;
  instr_t    orig_instr;
  logic      is_compressed;
  logic      illegal;

  // Decoder side
  modport lane (
    output op, rd, rs1, rs2, imm, pc, orig_instr, is_compressed, illegal
  );

  // Issue register side
  modport issue (
    input op, rd, rs1, rs2, imm, pc, orig_instr, is_compressed, illegal
  );

endinterface

// File: design/rvc_expander.sv
// ----------------------------------------
// RVC expander
// Rewrites C.ADDI, C.LI, C.J, C.MV, C.ADD
// and C.JR into 32-bit words; any other
// compressed encoding is flagged illegal
// ----------------------------------------

module rvc_expander (
  input  id_pkg::instr_t instr_i,
  output id_pkg::instr_t instr_o,
  output logic           is_compressed_o,
  output logic           illegal_o
);
  import id_pkg::*;

  cinstr_t    cinstr;
  reg_addr_t  rd_rs1;
  reg_addr_t  rs2;
  logic [2:0] funct3;
  logic [1:0] quadrant;

  assign cinstr   = instr_i[15:0];
  assign rd_rs1   = cinstr[11:7];
  assign rs2      = cinstr[6:2];
  assign funct3   = cinstr[15:13];
  assign quadrant = cinstr[1:0];

  // Quadrant 3 is the 32-bit space
  assign is_compressed_o = (quadrant != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;
    if (is_compressed_o) begin
      // Cleared by each supported form below
      illegal_o = 1'b1;
      case ({quadrant, funct3})
        // C.ADDI -> addi rd, rd, imm
        5'b01_000: begin
          instr_o   = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2], rd_rs1, 3'b000, rd_rs1,
                       OPC_OP_IMM};
          illegal_o = 1'b0;
        end
        // C.LI -> addi rd, x0, imm
        5'b01_010: begin
          instr_o   = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2], 5'd0, 3'b000, rd_rs1,
                       OPC_OP_IMM};
          illegal_o = 1'b0;
        end
        // C.J -> jal x0, offset
        5'b01_101: begin
          instr_o   = {cinstr[12], cinstr[8], cinstr[10:9], cinstr[6], cinstr[7], cinstr[2],
                       cinstr[11], cinstr[5:3], cinstr[12], {8{cinstr[12]}}, 5'd0, OPC_JAL};
          illegal_o = 1'b0;
        end
        // C.JR, C.MV and C.ADD share funct3 100
        5'b10_100: begin
          if (!cinstr[12]) begin
            if (rs2 == '0) begin
              // jalr x0, 0(rs1); rs1 = x0 is reserved
              if (rd_rs1 != '0) begin
                instr_o   = {12'd0, rd_rs1, 3'b000, 5'd0, OPC_JALR};
                illegal_o = 1'b0;
              end
            end else begin
              instr_o   = {7'd0, rs2, 5'd0, 3'b000, rd_rs1, OPC_OP};
              illegal_o = 1'b0;
            end
          end else if (rs2 != '0) begin
            instr_o   = {7'd0, rs2, rd_rs1, 3'b000, rd_rs1, OPC_OP};
            illegal_o = 1'b0;
          end
          // C.EBREAK and C.JALR stay illegal
        end
        default: begin
        end
      endcase
    end
  end

  // Only a compressed word can be refused here
  illegal_only_compressed: assert final (!illegal_o || is_compressed_o);

endmodule

// File: design/instr_decoder.sv
// ----------------------------------------
// Decode lane
// Expands RVC, classifies the opcode and
// extracts registers and the immediate
// ----------------------------------------

module instr_decoder (
  input  id_pkg::instr_t instr_i,
  input  id_pkg::pc_t    pc_i,
  id_lane_if.lane        entry_o
);
  import id_pkg::*;

  instr_t     exp_instr;
  logic       is_compressed;
  logic       rvc_illegal;
  logic [6:0] opcode;
  op_class_e  op;
  logic       opc_illegal;
  imm_t       imm;

  rvc_expander i_rvc_expander (
    .instr_i         (instr_i),
    .instr_o         (exp_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (rvc_illegal)
  );

  assign opcode = exp_instr[6:0];

  // ----------------------------------------
  // Class and immediate format
  // ----------------------------------------
  always_comb begin
    op          = OP_NONE;
    opc_illegal = 1'b0;
    imm         = '0;
    case (opcode)
      OPC_OP: op = OP_ALU;
      OPC_OP_IMM: begin
        op  = OP_ALU;
        imm = imm_t'(signed'(exp_instr[31:20]));
      end
      OPC_LUI, OPC_AUIPC: begin
        op  = OP_ALU;
        imm = imm_t'(signed'({exp_instr[31:12], 12'd0}));
      end
      OPC_LOAD: begin
        op  = OP_LOAD;
        imm = imm_t'(signed'(exp_instr[31:20]));
      end
      OPC_STORE: begin
        op  = OP_STORE;
        imm = imm_t'(signed'({exp_instr[31:25], exp_instr[11:7]}));
      end
      OPC_BRANCH: begin
        op  = OP_BRANCH;
        imm = imm_t'(signed'({exp_instr[31], exp_instr[7], exp_instr[30:25],
                              exp_instr[11:8], 1'b0}));
      end
      OPC_JAL: begin
        op  = OP_JUMP;
        imm = imm_t'(signed'({exp_instr[31], exp_instr[19:12], exp_instr[20],
                              exp_instr[30:21], 1'b0}));
      end
      OPC_JALR: begin
        op  = OP_JUMP;
        imm = imm_t'(signed'(exp_instr[31:20]));
      end
      default: opc_illegal = 1'b1;
    endcase
  end

  // Register fields sit at fixed positions
  assign entry_o.op            = op;
  assign entry_o.rd            = exp_instr[11:7];
  assign entry_o.rs1           = exp_instr[19:15];
  assign entry_o.rs2           = exp_instr[24:20];
  assign entry_o.imm           = imm;
  assign entry_o.pc            = pc_i;
  assign entry_o.orig_instr    = is_compressed ? {16'd0, instr_i[15:0]} : instr_i;
  assign entry_o.is_compressed = is_compressed;
  assign entry_o.illegal       = rvc_illegal | opc_illegal;

  // A known fetch word always yields a known class through the expander
  op_known: assert final ($isunknown(instr_i) || !$isunknown(entry_o.op));

endmodule

// File: design/issue_register.sv
// ----------------------------------------
// Issue register
// Two in-order slots between the decode
// lanes and issue; slot 0 is the oldest
// ----------------------------------------

`include "id_macros.svh"

module issue_register (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic [`ID_NR_LANES-1:0]                fetch_valid_i,
  output logic [`ID_NR_LANES-1:0]                fetch_ready_o,
  id_lane_if.issue                               lane_i [`ID_NR_LANES],
  output logic [`ID_NR_LANES-1:0]                issue_valid_o,
  input  logic [`ID_NR_LANES-1:0]                issue_ready_i,
  output id_pkg::op_class_e [`ID_NR_LANES-1:0]   issue_op_o,
  output id_pkg::reg_addr_t [`ID_NR_LANES-1:0]   issue_rd_o,
  output id_pkg::reg_addr_t [`ID_NR_LANES-1:0]   issue_rs1_o,
  output id_pkg::reg_addr_t [`ID_NR_LANES-1:0]   issue_rs2_o,
  output id_pkg::imm_t      [`ID_NR_LANES-1:0]   issue_imm_o,
  output id_pkg::pc_t       [`ID_NR_LANES-1:0]   issue_pc_o,
  output id_pkg::instr_t    [`ID_NR_LANES-1:0]   issue_instr_o,
  output logic              [`ID_NR_LANES-1:0]   issue_compressed_o,
  output logic              [`ID_NR_LANES-1:0]   issue_illegal_o,
  output logic              [`ID_NR_LANES-1:0]   issue_ctrl_flow_o
);
  import id_pkg::*;

  typedef struct packed {
    op_class_e op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm_t      imm;
    pc_t       pc;
    instr_t    instr;
    logic      compressed;
    logic      illegal;
  } slot_t;

  slot_t                   lane_entry [`ID_NR_LANES];
  slot_t                   slot_q     [`ID_NR_LANES];
  slot_t                   slot_n     [`ID_NR_LANES];
  logic [`ID_NR_LANES-1:0] valid_q;
  logic [`ID_NR_LANES-1:0] valid_n;

  for (genvar i = 0; i < `ID_NR_LANES; i++) begin : gen_slot
    assign lane_entry[i] = '{
      op:         lane_i[i].op,
      rd:         lane_i[i].rd,
      rs1:        lane_i[i].rs1,
      rs2:        lane_i[i].rs2,
      imm:        lane_i[i].imm,
      pc:         lane_i[i].pc,
      instr:      lane_i[i].orig_instr,
      compressed: lane_i[i].is_compressed,
      illegal:    lane_i[i].illegal
    };

    assign issue_op_o[i]         = slot_q[i].op;
    assign issue_rd_o[i]         = slot_q[i].rd;
    assign issue_rs1_o[i]        = slot_q[i].rs1;
    assign issue_rs2_o[i]        = slot_q[i].rs2;
    assign issue_imm_o[i]        = slot_q[i].imm;
    assign issue_pc_o[i]         = slot_q[i].pc;
    assign issue_instr_o[i]      = slot_q[i].instr;
    assign issue_compressed_o[i] = slot_q[i].compressed;
    assign issue_illegal_o[i]    = slot_q[i].illegal;
    assign issue_ctrl_flow_o[i]  = (slot_q[i].op == OP_BRANCH) || (slot_q[i].op == OP_JUMP);
  end

  assign issue_valid_o = valid_q;

  // ----------------------------------------
  // Next slot state
  // ----------------------------------------
  always_comb begin
    slot_n        = slot_q;
    valid_n       = valid_q & ~issue_ready_i;
    fetch_ready_o = '0;

    // Keep slot 0 the oldest
    if (!valid_n[0]) begin
      if (valid_n[1]) begin
        slot_n[0]  = slot_n[1];
        valid_n[0] = 1'b1;
        valid_n[1] = 1'b0;
      end else if (fetch_valid_i[0]) begin
        fetch_ready_o[0] = 1'b1;
        slot_n[0]        = lane_entry[0];
        valid_n[0]       = 1'b1;
      end
    end

    // Lane 1 follows lane 0, else lane 0 lands here
    if (!valid_n[1]) begin
      if (fetch_ready_o[0]) begin
        if (fetch_valid_i[1]) begin
          fetch_ready_o[1] = 1'b1;
          slot_n[1]        = lane_entry[1];
          valid_n[1]       = 1'b1;
        end
      end else if (fetch_valid_i[0]) begin
        fetch_ready_o[0] = 1'b1;
        slot_n[1]        = lane_entry[0];
        valid_n[1]       = 1'b1;
      end
    end

    if (flush_i) begin
      valid_n       = '0;
      fetch_ready_o = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  always_ff @(posedge clk_i) begin
    slot_q <= slot_n;
  end

  // ----------------------------------------
  // Ordering checks
  // ----------------------------------------
  lane1_after_lane0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_i[1] && fetch_ready_o[1]) |-> (fetch_valid_i[0] && fetch_ready_o[0]));

  slot1_needs_slot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q[1] |-> valid_q[0]);

  flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (issue_valid_o == '0));

endmodule

// File: design/id_stage_top.sv
// ----------------------------------------
// Decode stage top
// Fetch words go straight into one decode
// lane each; the issue register drains them
// ----------------------------------------

`include "id_macros.svh"

module id_stage_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic              [`ID_NR_LANES-1:0]   fetch_valid_i,
  output logic              [`ID_NR_LANES-1:0]   fetch_ready_o,
  input  id_pkg::instr_t    [`ID_NR_LANES-1:0]   fetch_instr_i,
  input  id_pkg::pc_t       [`ID_NR_LANES-1:0]   fetch_pc_i,
  output logic              [`ID_NR_LANES-1:0]   issue_valid_o,
  input  logic              [`ID_NR_LANES-1:0]   issue_ready_i,
  output id_pkg::op_class_e [`ID_NR_LANES-1:0]   issue_op_o,
  output id_pkg::reg_addr_t [`ID_NR_LANES-1:0]   issue_rd_o,
  output id_pkg::reg_addr_t [`ID_NR_LANES-1:0]   issue_rs1_o,
  output id_pkg::reg_addr_t [`ID_NR_LANES-1:0]   issue_rs2_o,
  output id_pkg::imm_t      [`ID_NR_LANES-1:0]   issue_imm_o,
  output id_pkg::pc_t       [`ID_NR_LANES-1:0]   issue_pc_o,
  output id_pkg::instr_t    [`ID_NR_LANES-1:0]   issue_instr_o,
  output logic              [`ID_NR_LANES-1:0]   issue_compressed_o,
  output logic              [`ID_NR_LANES-1:0]   issue_illegal_o,
  output logic              [`ID_NR_LANES-1:0]   issue_ctrl_flow_o
);

  // One decoded entry per lane
  id_lane_if lane_if [`ID_NR_LANES] ();

  for (genvar i = 0; i < `ID_NR_LANES; i++) begin : gen_lane
    instr_decoder i_instr_decoder (
      .instr_i (fetch_instr_i[i]),
      .pc_i    (fetch_pc_i[i]),
      .entry_o (lane_if[i])
    );
  end

  issue_register i_issue_register (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_ready_o      (fetch_ready_o),
    .lane_i             (lane_if),
    .issue_valid_o      (issue_valid_o),
    .issue_ready_i      (issue_ready_i),
    .issue_op_o         (issue_op_o),
    .issue_rd_o         (issue_rd_o),
    .issue_rs1_o        (issue_rs1_o),
    .issue_rs2_o        (issue_rs2_o),
    .issue_imm_o        (issue_imm_o),
    .issue_pc_o         (issue_pc_o),
    .issue_instr_o      (issue_instr_o),
    .issue_compressed_o (issue_compressed_o),
    .issue_illegal_o    (issue_illegal_o),
    .issue_ctrl_flow_o  (issue_ctrl_flow_o)
  );

endmodule

// File: sim/tb_id_stage.sv
// ----------------------------------------
// Decode stage testbench
// Random fetch and issue traffic against a
// queue model, checked by assertions
// ----------------------------------------

`include "id_macros.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import id_pkg::*;

  localparam int n_instr     = 400;
  localparam int ready_phase = 150;
  localparam int cycle_limit = 20 * n_instr;

  typedef struct packed {
    op_class_e op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm_t      imm;
    pc_t       pc;
    instr_t    instr;
    logic      compressed;
    logic      illegal;
    logic      ctrl_flow;
  } entry_t;

  logic                                clk_i;
  logic                                rst_ni;
  logic                                flush_i;
  logic              [`ID_NR_LANES-1:0] fetch_valid_i;
  logic              [`ID_NR_LANES-1:0] fetch_ready_o;
  instr_t            [`ID_NR_LANES-1:0] fetch_instr_i;
  pc_t               [`ID_NR_LANES-1:0] fetch_pc_i;
  logic              [`ID_NR_LANES-1:0] issue_valid_o;
  logic              [`ID_NR_LANES-1:0] issue_ready_i;
  op_class_e         [`ID_NR_LANES-1:0] issue_op_o;
  reg_addr_t         [`ID_NR_LANES-1:0] issue_rd_o;
  reg_addr_t         [`ID_NR_LANES-1:0] issue_rs1_o;
  reg_addr_t         [`ID_NR_LANES-1:0] issue_rs2_o;
  imm_t              [`ID_NR_LANES-1:0] issue_imm_o;
  pc_t               [`ID_NR_LANES-1:0] issue_pc_o;
  instr_t            [`ID_NR_LANES-1:0] issue_instr_o;
  logic              [`ID_NR_LANES-1:0] issue_compressed_o;
  logic              [`ID_NR_LANES-1:0] issue_illegal_o;
  logic              [`ID_NR_LANES-1:0] issue_ctrl_flow_o;

  logic [31:0]             lfsr_state = 32'd74073;
  instr_t                  stream_instr [n_instr+2];
  pc_t                     stream_pc    [n_instr+2];
  entry_t                  model_q [$];
  entry_t                  exp_slot [`ID_NR_LANES];
  entry_t                  dut_slot [`ID_NR_LANES];
  logic [`ID_NR_LANES-1:0] exp_valid = '0;
  logic [`ID_NR_LANES-1:0] exp_ready;
  int                      fetch_idx = 0;
  int                      took = 0;
  int                      cycle_cnt = 0;

  id_stage_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic mismatch(string name, logic [127:0] expected, logic [127:0] actual);
    $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    abort_run();
  endtask

  // Galois LFSR stepped once per random bit
  function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'hB4BCD35C;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // Directed RVC forms, base opcodes and random words
  function automatic instr_t gen_word();
    instr_t     w;
    logic [3:0] kind;
    w    = rand_bits(32);
    kind = 4'(rand_bits(4));
    case (kind)
      4'd0: w[15:0] = {3'b000, w[12:2], 2'b01};
      4'd1: w[15:0] = {3'b010, w[12:2], 2'b01};
      4'd2: w[15:0] = {3'b101, w[12:2], 2'b01};
      4'd3: w[15:0] = {4'b1000, w[11:2], 2'b10};
      4'd4: w[15:0] = {4'b1001, w[11:2], 2'b10};
      4'd5: w[15:0] = {4'b1000, w[11:7], 5'd0, 2'b10};
      4'd6: w[15:0] = '0;
      4'd7: w[0] = w[0] & ~w[1];
      4'd8: w[6:0] = OPC_OP;
      4'd9: w[6:0] = OPC_OP_IMM;
      4'd10: w[6:0] = OPC_LUI;
      4'd11: w[6:0] = OPC_AUIPC;
      4'd12: w[6:0] = OPC_LOAD;
      4'd13: w[6:0] = OPC_STORE;
      4'd14: w[6:0] = OPC_BRANCH;
      default: w[6:0] = w[8] ? {w[6:2], 2'b11} : (w[7] ? OPC_JAL : OPC_JALR);
    endcase
    return w;
  endfunction

  // Expected entry from the RV32I and RVC encodings
  function automatic entry_t predict(instr_t w, pc_t pc);
    cinstr_t     c;
    instr_t      x;
    logic [11:0] ci_imm;
    logic [11:0] cj_off;
    entry_t      e;
    c            = w[15:0];
    ci_imm       = {{6{c[12]}}, c[12], c[6:2]};
    cj_off       = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    e.compressed = (c[1:0] != 2'b11);
    e.illegal    = 1'b0;
    x            = w;
    if (e.compressed) begin
      if (c[1:0] == 2'b01 && c[15:13] == 3'b000)
        x = {ci_imm, c[11:7], 3'b000, c[11:7], OPC_OP_IMM};
      else if (c[1:0] == 2'b01 && c[15:13] == 3'b010)
        x = {ci_imm, 5'd0, 3'b000, c[11:7], OPC_OP_IMM};
      else if (c[1:0] == 2'b01 && c[15:13] == 3'b101)
        x = {cj_off[11], cj_off[10:1], cj_off[11], {8{cj_off[11]}}, 5'd0, OPC_JAL};
      else if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && c[6:2] != 5'd0)
        x = {7'd0, c[6:2], 5'd0, 3'b000, c[11:7], OPC_OP};
      else if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && c[11:7] != 5'd0)
        x = {12'd0, c[11:7], 3'b000, 5'd0, OPC_JALR};
      else if (c[1:0] == 2'b10 && c[15:12] == 4'b1001 && c[6:2] != 5'd0)
        x = {7'd0, c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP};
      else
        e.illegal = 1'b1;
    end
    e.rd    = x[11:7];
    e.rs1   = x[19:15];
    e.rs2   = x[24:20];
    e.pc    = pc;
    e.instr = e.compressed ? {16'd0, c} : w;
    e.imm   = '0;
    case (x[6:0])
      OPC_OP: e.imm = '0;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: e.imm = {{20{x[31]}}, x[31:20]};
      OPC_LUI, OPC_AUIPC: e.imm = {x[31:12], 12'd0};
      OPC_STORE: e.imm = {{20{x[31]}}, x[31:25], x[11:7]};
      OPC_BRANCH: e.imm = {{19{x[31]}}, x[31], x[7], x[30:25], x[11:8], 1'b0};
      OPC_JAL: e.imm = {{11{x[31]}}, x[31], x[19:12], x[20], x[30:21], 1'b0};
      default: e.illegal = 1'b1;
    endcase
    case (x[6:0])
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: e.op = OP_ALU;
      OPC_LOAD: e.op = OP_LOAD;
      OPC_STORE: e.op = OP_STORE;
      OPC_BRANCH: e.op = OP_BRANCH;
      OPC_JAL, OPC_JALR: e.op = OP_JUMP;
      default: e.op = OP_NONE;
    endcase
    // Branches and both jump opcodes redirect the PC
    e.ctrl_flow = (x[6:0] == OPC_BRANCH) || (x[6:0] == OPC_JAL) || (x[6:0] == OPC_JALR);
    return e;
  endfunction

  // ----------------------------------------
  // Queue model of the issue slots
  // ----------------------------------------
  // A slot is free when empty or issued this cycle
  always_comb begin
    int free;
    free = 0;
    for (int i = 0; i < `ID_NR_LANES; i++) begin
      if (!(exp_valid[i] && !issue_ready_i[i]))
        free++;
    end
    exp_ready[0] = !flush_i && fetch_valid_i[0] && (free >= 1);
    exp_ready[1] = !flush_i && fetch_valid_i[1] && exp_ready[0] && (free >= 2);
  end

  always @(posedge clk_i or negedge rst_ni) begin
    took = 0;
    if (!rst_ni) begin
      model_q.delete();
    end else if (flush_i) begin
      model_q.delete();
    end else begin
      for (int i = 0; i < `ID_NR_LANES; i++) begin
        if (exp_valid[i] && issue_ready_i[i])
          void'(model_q.pop_front());
      end
      for (int i = 0; i < `ID_NR_LANES; i++) begin
        if (exp_ready[i]) begin
          model_q.push_back(predict(fetch_instr_i[i], fetch_pc_i[i]));
          took++;
        end
      end
    end
    for (int i = 0; i < `ID_NR_LANES; i++) begin
      exp_valid[i] = (model_q.size() > i);
      if (exp_valid[i])
        exp_slot[i] = model_q[i];
    end
  end

  // ----------------------------------------
  // Checks on the DUT ports
  // ----------------------------------------
  reset_idle: assert property (@(posedge clk_i)
    !rst_ni |=> (issue_valid_o == '0 && fetch_ready_o == '0))
    else mismatch("reset_idle", '0, {$sampled(issue_valid_o), $sampled(fetch_ready_o)});

  ready_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ready_o === exp_ready)
    else mismatch("fetch_ready", $sampled(exp_ready), $sampled(fetch_ready_o));

  valid_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o === exp_valid)
    else mismatch("issue_valid", $sampled(exp_valid), $sampled(issue_valid_o));

  lane_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ready_o[1] |-> fetch_ready_o[0])
    else mismatch("lane_order", 2'b11, $sampled(fetch_ready_o));

  // Both slots held means nothing is taken
  full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&issue_valid_o && !(|(issue_valid_o & issue_ready_i))) |-> fetch_ready_o == '0)
    else mismatch("full_stall", '0, $sampled(fetch_ready_o));

  latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&issue_ready_i && !flush_i && fetch_valid_i[0] && fetch_ready_o[0])
    |=> (issue_valid_o[0] && issue_pc_o[0] === $past(fetch_pc_i[0])))
    else begin
      $display("Accepted lane 0 word did not reach slot 0 one cycle later");
      abort_run();
    end

  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> issue_valid_o == '0)
    else mismatch("flush", '0, $sampled(issue_valid_o));

  for (genvar i = 0; i < `ID_NR_LANES; i++) begin : gen_slot_check
    assign dut_slot[i] = {issue_op_o[i], issue_rd_o[i], issue_rs1_o[i], issue_rs2_o[i],
                          issue_imm_o[i], issue_pc_o[i], issue_instr_o[i],
                          issue_compressed_o[i], issue_illegal_o[i], issue_ctrl_flow_o[i]};

    slot_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
      exp_valid[i] |-> dut_slot[i] === exp_slot[i])
      else mismatch($sformatf("slot%0d_entry", i), $sampled(exp_slot[i]),
                    $sampled(dut_slot[i]));
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles with instructions still pending", cycle_cnt);
      abort_run();
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    pc_t        pc;
    logic [1:0] r;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = '0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    issue_ready_i = '0;
    pc            = 32'h8000_0000;
    for (int k = 0; k < n_instr + 2; k++) begin
      stream_instr[k] = gen_word();
      stream_pc[k]    = pc;
      pc              = pc + ((stream_instr[k][1:0] == 2'b11) ? 32'd4 : 32'd2);
    end
    repeat (10) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    // Idle with nothing offered by fetch
    repeat (5) @(posedge clk_i);
    forever begin
      #2;
      fetch_idx = fetch_idx + took;
      if (fetch_idx == n_instr && model_q.size() == 0)
        break;
      fetch_valid_i[0] = (fetch_idx < n_instr) && (rand_bits(2) != 0);
      fetch_valid_i[1] = (fetch_idx + 1 < n_instr) && (rand_bits(1) == 1);
      fetch_instr_i[0] = stream_instr[fetch_idx];
      fetch_instr_i[1] = stream_instr[fetch_idx+1];
      fetch_pc_i[0]    = stream_pc[fetch_idx];
      fetch_pc_i[1]    = stream_pc[fetch_idx+1];
      if (fetch_idx < ready_phase) begin
        issue_ready_i = '1;
        flush_i       = 1'b0;
      end else begin
        // In-order consumer with rare flushes
        r             = 2'(rand_bits(2));
        issue_ready_i = {r == 2'd3, r != 2'd0};
        flush_i       = (rand_bits(5) == 0);
      end
      @(posedge clk_i);
    end
    fetch_valid_i = '0;
    flush_i       = 1'b0;
    repeat (3) @(posedge clk_i);
    $display("No errors");
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
design/id_pkg.sv
design/id_lane_if.sv
design/rvc_expander.sv
design/instr_decoder.sv
design/issue_register.sv
design/id_stage_top.sv
sim/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - design/id_pkg.sv
      - design/id_lane_if.sv
      - design/rvc_expander.sv
      - design/instr_decoder.sv
      - design/issue_register.sv
      - design/id_stage_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_id_stage.sv
